/* logic/mmu_pkg.sv */
package mmu_pkg;

    // cpu side word, used for both addresses and data
    typedef logic [31:0] word_t;

    // sram word address, 1M words per bank
    typedef logic [19:0] sram_addr_t;

    // byte lane enables, active low, lane 3 is bits 31:24
    typedef logic [3:0] be_n_t;

    typedef logic [7:0] byte_t;

    // access target picked by the address decoder
    typedef logic [1:0] target_t;

    localparam target_t TGT_BASE      = 2'd0;
    localparam target_t TGT_EXT       = 2'd1;
    localparam target_t TGT_UART_DATA = 2'd2;
    localparam target_t TGT_UART_STAT = 2'd3;

    // access FSM, one idle cycle and one strobe cycle
    typedef enum logic {
        ST_IDLE   = 1'b0,
        ST_STROBE = 1'b1
    } ctrl_state_t;

    localparam word_t DEF_UART_DATA_ADDR = 32'hBFD0_03F8;
    localparam word_t DEF_UART_STAT_ADDR = 32'hBFD0_03FD;

endpackage

/* logic/addr_decode.sv */
`timescale 1ns/1ps

module addr_decode import mmu_pkg::*; #(
    parameter word_t UART_DATA_ADDR = DEF_UART_DATA_ADDR,
    parameter word_t UART_STAT_ADDR = DEF_UART_STAT_ADDR
) (
    input  word_t      addr,
    output target_t    target,
    output sram_addr_t word_addr
);

    logic hit_data;
    logic hit_stat;

    // uart registers are matched on the full address
    assign hit_data = (addr == UART_DATA_ADDR);
    assign hit_stat = (addr == UART_STAT_ADDR);

    always_comb begin
        if (hit_data) begin
            target = TGT_UART_DATA;
        end else if (hit_stat) begin
            target = TGT_UART_STAT;
        end else if (addr[22]) begin
            target = TGT_EXT;       // upper 4MB window
        end else begin
            target = TGT_BASE;
        end
    end

    assign word_addr = addr[21:2]; // both banks share the same word index

endmodule

/* logic/mmu_ctrl.sv */
`timescale 1ns/1ps

module mmu_ctrl import mmu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        if_read,
    input  logic        if_write,
    input  target_t     target,
    output logic        base_sel,
    output logic        ext_sel,
    output logic        rd_op,
    output logic        wr_op,
    output logic        uart_rd,
    output logic        uart_wr,
    output logic        capture,
    output ctrl_state_t state
);

    logic        req;
    logic        accept;
    logic        rd_q;      // latched operation, high for reads
    ctrl_state_t state_d;

    assign req    = if_read | if_write;
    assign accept = (state == ST_IDLE) && req;

    // strobe set for the access being accepted; the port and uart pin
    // flops pick it up at the accepting edge, so it shows up in ST_STROBE
    always_comb begin
        rd_op    = accept && if_read;
        wr_op    = accept && !if_read;     // read wins if both strobes are high
        base_sel = accept && (target == TGT_BASE);
        ext_sel  = accept && (target == TGT_EXT);
        uart_rd  = rd_op && (target == TGT_UART_DATA);
        uart_wr  = wr_op && (target == TGT_UART_DATA);
    end

    always_comb begin
        state_d = state;
        case (state)
            ST_IDLE: begin
                if (req) begin
                    state_d = ST_STROBE;
                end
            end
            ST_STROBE: state_d = ST_IDLE;   // requests here are dropped
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            rd_q  <= 1'b0;
        end else begin
            state <= state_d;
            if (accept) begin
                rd_q <= if_read;
            end
        end
    end

    // read data is sampled on the edge that ends the strobe cycle;
    // every target returns data on a read, status reads included
    assign capture = (state == ST_STROBE) && rd_q;

endmodule

/* logic/byte_lane.sv */
`timescale 1ns/1ps

module byte_lane import mmu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       load,
    input  logic       bytemode,
    input  logic [1:0] addr_lsb,
    input  word_t      input_data,
    input  word_t      bus_data,
    output word_t      wr_data,
    output be_n_t      be_n,
    output word_t      rd_data
);

    logic       byte_q;
    logic [1:0] off_q;
    byte_t      rd_byte;

    always_ff @(posedge clk) begin
        if (reset) begin
            be_n   <= 4'b1111;
            byte_q <= 1'b0;
            off_q  <= 2'd0;
        end else if (load) begin
            byte_q <= bytemode;
            off_q  <= addr_lsb;
            if (bytemode) begin
                be_n <= ~(4'b1000 >> addr_lsb); // big endian, offset 0 is lane 3
            end else begin
                be_n <= 4'b0000;
            end
        end
    end

    // in byte mode the low byte goes to every lane, be_n picks the one written
    always_ff @(posedge clk) begin
        if (load) begin
            if (bytemode) begin
                wr_data <= {4{input_data[7:0]}};
            end else begin
                wr_data <= input_data;
            end
        end
    end

    always_comb begin
        case (off_q)
            2'd0:    rd_byte = bus_data[31:24];
            2'd1:    rd_byte = bus_data[23:16];
            2'd2:    rd_byte = bus_data[15:8];
            default: rd_byte = bus_data[7:0];
        endcase
    end

    assign rd_data = byte_q ? {{24{rd_byte[7]}}, rd_byte} : bus_data;

endmodule

/* logic/sram_port.sv */
`timescale 1ns/1ps

module sram_port import mmu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       sel,
    input  logic       rd_op,
    input  logic       wr_op,
    input  sram_addr_t word_addr,
    input  word_t      wr_data,
    input  be_n_t      be_n_in,
    inout  wire word_t ram_data,
    output sram_addr_t ram_addr,
    output be_n_t      ram_be_n,
    output logic       ram_ce_n,
    output logic       ram_oe_n,
    output logic       ram_we_n
);

    always_ff @(posedge clk) begin
        if (reset) begin
            ram_ce_n <= 1'b1;
            ram_oe_n <= 1'b1;
            ram_we_n <= 1'b1;
        end else begin
            ram_ce_n <= ~sel;
            ram_oe_n <= ~(sel & rd_op);
            ram_we_n <= ~(sel & wr_op);
        end
    end

    // address only moves on an access to this bank
    always_ff @(posedge clk) begin
        if (sel) begin
            ram_addr <= word_addr;
        end
    end

    assign ram_be_n = ram_ce_n ? 4'b1111 : be_n_in; // idle bank shows no lanes

    assign ram_data = ram_we_n ? 'z : wr_data;

endmodule

/* logic/mmu.sv */
`timescale 1ns/1ps

module mmu import mmu_pkg::*; #(
    parameter word_t UART_DATA_ADDR = DEF_UART_DATA_ADDR,
    parameter word_t UART_STAT_ADDR = DEF_UART_STAT_ADDR
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       if_read,
    input  logic       if_write,
    input  logic       bytemode,
    input  word_t      addr,
    input  word_t      input_data,
    output word_t      output_data,
    inout  wire word_t base_ram_data,
    inout  wire word_t ext_ram_data,
    output sram_addr_t base_ram_addr,
    output sram_addr_t ext_ram_addr,
    output be_n_t      base_ram_be_n,
    output be_n_t      ext_ram_be_n,
    output logic       base_ram_ce_n,
    output logic       base_ram_oe_n,
    output logic       base_ram_we_n,
    output logic       ext_ram_ce_n,
    output logic       ext_ram_oe_n,
    output logic       ext_ram_we_n,
    output logic       uart_rdn,
    output logic       uart_wrn,
    input  logic       uart_dataready,
    input  logic       uart_tbre,
    input  logic       uart_tsre
);

    target_t     target;
    sram_addr_t  word_addr;
    logic        base_sel, ext_sel;
    logic        rd_op, wr_op;
    logic        uart_rd, uart_wr;
    logic        capture;
    ctrl_state_t state;
    word_t       wr_data, bus_data, rd_data;
    be_n_t       be_n;
    byte_t       uart_tx;
    logic        dataready_q, tsre_q;

    addr_decode #(
        .UART_DATA_ADDR (UART_DATA_ADDR),
        .UART_STAT_ADDR (UART_STAT_ADDR)
    ) addr_decode_i (
        .addr      (addr),
        .target    (target),
        .word_addr (word_addr)
    );

    mmu_ctrl mmu_ctrl_i (
        .clk      (clk),
        .reset    (reset),
        .if_read  (if_read),
        .if_write (if_write),
        .target   (target),
        .base_sel (base_sel),
        .ext_sel  (ext_sel),
        .rd_op    (rd_op),
        .wr_op    (wr_op),
        .uart_rd  (uart_rd),
        .uart_wr  (uart_wr),
        .capture  (capture),
        .state    (state)
    );

    assign bus_data = ext_ram_ce_n ? base_ram_data : ext_ram_data;

    byte_lane byte_lane_i (
        .clk        (clk),
        .reset      (reset),
        .load       (rd_op | wr_op),
        .bytemode   (bytemode),
        .addr_lsb   (addr[1:0]),
        .input_data (input_data),
        .bus_data   (bus_data),
        .wr_data    (wr_data),
        .be_n       (be_n),
        .rd_data    (rd_data)
    );

    sram_port base_port_i (
        .clk       (clk),
        .reset     (reset),
        .sel       (base_sel),
        .rd_op     (rd_op),
        .wr_op     (wr_op),
        .word_addr (word_addr),
        .wr_data   (wr_data),
        .be_n_in   (be_n),
        .ram_data  (base_ram_data),
        .ram_addr  (base_ram_addr),
        .ram_be_n  (base_ram_be_n),
        .ram_ce_n  (base_ram_ce_n),
        .ram_oe_n  (base_ram_oe_n),
        .ram_we_n  (base_ram_we_n)
    );

    sram_port ext_port_i (
        .clk       (clk),
        .reset     (reset),
        .sel       (ext_sel),
        .rd_op     (rd_op),
        .wr_op     (wr_op),
        .word_addr (word_addr),
        .wr_data   (wr_data),
        .be_n_in   (be_n),
        .ram_data  (ext_ram_data),
        .ram_addr  (ext_ram_addr),
        .ram_be_n  (ext_ram_be_n),
        .ram_ce_n  (ext_ram_ce_n),
        .ram_oe_n  (ext_ram_oe_n),
        .ram_we_n  (ext_ram_we_n)
    );

    // uart pins, strobes line up with the sram strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            uart_rdn    <= 1'b1;
            uart_wrn    <= 1'b1;
            dataready_q <= 1'b0;
            tsre_q      <= 1'b0;
        end else begin
            uart_rdn    <= ~uart_rd;
            uart_wrn    <= ~uart_wr;
            dataready_q <= uart_dataready;
            tsre_q      <= uart_tsre;
        end
    end

    always_ff @(posedge clk) begin
        if (uart_wr) begin
            uart_tx <= input_data[7:0];
        end
    end

    // the uart sits on the low byte of the base bus
    assign base_ram_data = uart_wrn ? 'z : {24'b0, uart_tx};

    // source is known from which strobe is active in this cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            output_data <= '0;
        end else if (capture) begin
            if (!uart_rdn) begin
                output_data <= {24'b0, base_ram_data[7:0]};
            end else if (!base_ram_ce_n || !ext_ram_ce_n) begin
                output_data <= rd_data;
            end else begin
                output_data <= {30'b0, dataready_q, tsre_q}; // status read
            end
        end
    end

endmodule

/* dv/board_model.sv */
`timescale 1ns/1ps

// asynchronous 1M x 32 sram bank with active low lane enables
module sram_bank import mmu_pkg::*; #(
    parameter logic [11:0] TAG = 12'h000
) (
    input  logic       ce_n,
    input  logic       oe_n,
    input  logic       we_n,
    input  sram_addr_t addr,
    input  be_n_t      be_n,
    inout  wire word_t data
);

    word_t mem [0:(1 << 20) - 1];
    int    write_count = 0;

    // tag in the upper bits keeps the two banks apart
    initial begin
        for (int i = 0; i < (1 << 20); i++) begin
            mem[i] = {TAG ^ i[19:8], i[19:0]};
        end
    end

    assign data = (!ce_n && !oe_n && we_n) ? mem[addr] : 'z;

    // write lands once address and data have settled after we_n falls
    always @(negedge we_n) begin
        #10;
        if (!ce_n && !we_n) begin
            for (int i = 0; i < 4; i++) begin
                if (!be_n[i]) begin
                    mem[addr][8 * i +: 8] = data[8 * i +: 8];
                end
            end
            write_count++;
        end
    end

endmodule

// uart on the low byte of the base bus
module uart_model import mmu_pkg::*; (
    input  logic       rdn,
    input  logic       wrn,
    input  byte_t      rx_byte,
    inout  wire word_t data
);

    byte_t tx_byte = '0;
    int    tx_count = 0;

    // upper lines are not wired on the board, read as ones here
    assign data = rdn ? 'z : {24'hFF_FFFF, rx_byte};

    always @(negedge wrn) begin
        #10;
        if (!wrn) begin
            tx_byte = data[7:0];
            tx_count++;
        end
    end

endmodule

/* dv/mmu_assert.sv */
`timescale 1ns/1ps

module mmu_assert import mmu_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        if_read,
    input logic        if_write,
    input logic        base_ram_ce_n,
    input logic        base_ram_oe_n,
    input logic        base_ram_we_n,
    input logic        ext_ram_ce_n,
    input logic        ext_ram_oe_n,
    input logic        ext_ram_we_n,
    input logic        uart_rdn,
    input logic        uart_wrn,
    input ctrl_state_t state
);

    logic [7:0] strobe_n;

    assign strobe_n = {base_ram_ce_n, base_ram_oe_n, base_ram_we_n,
                       ext_ram_ce_n, ext_ram_oe_n, ext_ram_we_n, uart_rdn, uart_wrn};

    bank_exclusive: assert property (@(posedge clk) disable iff (reset)
        base_ram_ce_n || ext_ram_ce_n)
        else $error("both sram banks selected at once");

    // a low strobe is back high on the next edge
    strobe_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (strobe_n != 8'hFF) |=> (strobe_n == 8'hFF))
        else $error("strobe held low for more than one cycle");

    strobe_in_state: assert property (@(posedge clk) disable iff (reset)
        (strobe_n != 8'hFF) |-> (state == ST_STROBE))
        else $error("strobe active outside ST_STROBE");

    read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(if_read && if_write))
        else $error("if_read and if_write high together");

endmodule

bind mmu mmu_assert mmu_assert_i (
    .clk           (clk),
    .reset         (reset),
    .if_read       (if_read),
    .if_write      (if_write),
    .base_ram_ce_n (base_ram_ce_n),
    .base_ram_oe_n (base_ram_oe_n),
    .base_ram_we_n (base_ram_we_n),
    .ext_ram_ce_n  (ext_ram_ce_n),
    .ext_ram_oe_n  (ext_ram_oe_n),
    .ext_ram_we_n  (ext_ram_we_n),
    .uart_rdn      (uart_rdn),
    .uart_wrn      (uart_wrn),
    .state         (state)
);

/* dv/mmu_tb.sv */
`timescale 1ns/1ps

module mmu_tb import mmu_pkg::*; ();

    localparam int    TIMEOUT_CYCLES = 400;          // several times the whole run
    localparam word_t EXT_BIT        = 32'h0040_0000;
    localparam word_t SRAM_MASK      = 32'h003F_FFFC; // word aligned, base bank

    logic       clk;
    logic       reset;
    logic       if_read;
    logic       if_write;
    logic       bytemode;
    word_t      addr;
    word_t      input_data;
    word_t      output_data;
    wire word_t base_ram_data;
    wire word_t ext_ram_data;
    sram_addr_t base_ram_addr, ext_ram_addr;
    be_n_t      base_ram_be_n, ext_ram_be_n;
    logic       base_ram_ce_n, base_ram_oe_n, base_ram_we_n;
    logic       ext_ram_ce_n, ext_ram_oe_n, ext_ram_we_n;
    logic       uart_rdn, uart_wrn;
    logic       uart_dataready, uart_tsre;
    byte_t      uart_rx;

    logic [7:0] strobe_n;   // strobes seen during the strobe cycle
    word_t      bus_snap;   // base bus in the same cycle
    word_t      rng;
    int         errors = 0;
    int         tests = 0;
    int         cycles = 0;

    mmu mmu_i (
        .clk            (clk),
        .reset          (reset),
        .if_read        (if_read),
        .if_write       (if_write),
        .bytemode       (bytemode),
        .addr           (addr),
        .input_data     (input_data),
        .output_data    (output_data),
        .base_ram_data  (base_ram_data),
        .ext_ram_data   (ext_ram_data),
        .base_ram_addr  (base_ram_addr),
        .ext_ram_addr   (ext_ram_addr),
        .base_ram_be_n  (base_ram_be_n),
        .ext_ram_be_n   (ext_ram_be_n),
        .base_ram_ce_n  (base_ram_ce_n),
        .base_ram_oe_n  (base_ram_oe_n),
        .base_ram_we_n  (base_ram_we_n),
        .ext_ram_ce_n   (ext_ram_ce_n),
        .ext_ram_oe_n   (ext_ram_oe_n),
        .ext_ram_we_n   (ext_ram_we_n),
        .uart_rdn       (uart_rdn),
        .uart_wrn       (uart_wrn),
        .uart_dataready (uart_dataready),
        .uart_tbre      (1'b1),
        .uart_tsre      (uart_tsre)
    );

    sram_bank #(.TAG(12'hBA5)) base_bank (
        .ce_n (base_ram_ce_n),
        .oe_n (base_ram_oe_n),
        .we_n (base_ram_we_n),
        .addr (base_ram_addr),
        .be_n (base_ram_be_n),
        .data (base_ram_data)
    );

    sram_bank #(.TAG(12'hE47)) ext_bank (
        .ce_n (ext_ram_ce_n),
        .oe_n (ext_ram_oe_n),
        .we_n (ext_ram_we_n),
        .addr (ext_ram_addr),
        .be_n (ext_ram_be_n),
        .data (ext_ram_data)
    );

    uart_model uart_dev (
        .rdn     (uart_rdn),
        .wrn     (uart_wrn),
        .rx_byte (uart_rx),
        .data    (base_ram_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    function automatic word_t next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // ce, oe, we of each bank then rdn, wrn; all ones when idle
    function automatic logic [7:0] strobes();
        return {base_ram_ce_n, base_ram_oe_n, base_ram_we_n,
                ext_ram_ce_n, ext_ram_oe_n, ext_ram_we_n, uart_rdn, uart_wrn};
    endfunction

    function automatic logic [7:0] expected_strobes(input logic rd, input word_t a);
        if (a == DEF_UART_DATA_ADDR) begin
            return rd ? 8'hFD : 8'hFE;
        end else if (a == DEF_UART_STAT_ADDR) begin
            return 8'hFF;   // status read has no strobe
        end else if (a[22]) begin
            return rd ? 8'hE7 : 8'hEB;
        end
        return rd ? 8'h3F : 8'h5F;
    endfunction

    function automatic word_t bank_word(input word_t a);
        if (a[22]) begin
            return ext_bank.mem[a[21:2]];
        end
        return base_bank.mem[a[21:2]];
    endfunction

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        errors++;
        $display("FAILED %s expected %08h actual %08h", name, exp, act);
    endtask

    // one request, returns 2 ns after the edge that captures read data
    task automatic access(input string name, input logic rd, input word_t a,
                          input word_t d, input logic bm);
        if_read    = rd;
        if_write   = !rd;
        addr       = a;
        input_data = d;
        bytemode   = bm;
        @(posedge clk);
        #2;
        if_read  = 1'b0;
        if_write = 1'b0;
        strobe_n = strobes();
        bus_snap = base_ram_data;
        if (strobe_n !== expected_strobes(rd, a)) begin
            report_mismatch({name, "_strobes"}, {24'h0, expected_strobes(rd, a)},
                            {24'h0, strobe_n});
        end
        @(posedge clk);
        #2;
        if (strobes() !== 8'hFF) begin
            report_mismatch({name, "_release"}, 32'hFF, {24'h0, strobes()});
        end
    endtask

    // strobe held for two edges, the second lands in ST_STROBE
    task automatic back_to_back(input string name, input logic rd, input word_t a1,
                                input word_t d1, input word_t a2, input word_t d2);
        if_read    = rd;
        if_write   = !rd;
        addr       = a1;
        input_data = d1;
        bytemode   = 1'b0;
        @(posedge clk);
        #2;
        addr       = a2;
        input_data = d2;
        @(posedge clk);
        #2;
        if_read  = 1'b0;
        if_write = 1'b0;
        if (strobes() !== 8'hFF) begin
            report_mismatch({name, "_second"}, 32'hFF, {24'h0, strobes()});
        end
        @(posedge clk);
        #2;
    endtask

    task automatic test_reset();
        tests++;
        if (strobes() !== 8'hFF) begin
            report_mismatch("reset_strobes", 32'hFF, {24'h0, strobes()});
        end
        if (output_data !== 32'h0) begin
            report_mismatch("reset_output", 32'h0, output_data);
        end
    endtask

    task automatic test_word_rw();
        word_t a_base;
        word_t a_ext;
        word_t d_base;
        word_t d_ext;
        int    base_writes;
        int    ext_writes;
        tests++;
        a_base      = next_random() & SRAM_MASK;
        a_ext       = a_base | EXT_BIT;    // same word index, other bank
        d_base      = next_random();
        d_ext       = next_random();
        base_writes = base_bank.write_count;
        ext_writes  = ext_bank.write_count;
        access("word_write_base", 1'b0, a_base, d_base, 1'b0);
        access("word_write_ext", 1'b0, a_ext, d_ext, 1'b0);
        if (base_bank.write_count != base_writes + 1) begin
            report_mismatch("word_base_writes", base_writes + 1, base_bank.write_count);
        end
        if (ext_bank.write_count != ext_writes + 1) begin
            report_mismatch("word_ext_writes", ext_writes + 1, ext_bank.write_count);
        end
        access("word_read_base", 1'b1, a_base, '0, 1'b0);
        if (output_data !== d_base) begin
            report_mismatch("word_read_base", d_base, output_data);
        end
        access("word_read_ext", 1'b1, a_ext, '0, 1'b0);
        if (output_data !== d_ext) begin
            report_mismatch("word_read_ext", d_ext, output_data);
        end
    endtask

    task automatic test_bytes();
        word_t a;
        word_t d;
        word_t exp_mem;
        byte_t b;
        tests++;
        a       = (next_random() & SRAM_MASK) | EXT_BIT;
        exp_mem = next_random();
        access("byte_setup", 1'b0, a, exp_mem, 1'b0);
        for (int k = 0; k < 4; k++) begin
            d    = next_random();
            d[7] = k[0];   // both signs for the reads below
            access("byte_write", 1'b0, a + k, d, 1'b1);
            exp_mem[31 - 8 * k -: 8] = d[7:0];   // offset 0 is the top byte
            if (bank_word(a) !== exp_mem) begin
                report_mismatch("byte_write", exp_mem, bank_word(a));
            end
        end
        for (int k = 0; k < 4; k++) begin
            b = exp_mem[31 - 8 * k -: 8];
            access("byte_read", 1'b1, a + k, '0, 1'b1);
            if (output_data !== {{24{b[7]}}, b}) begin
                report_mismatch("byte_read", {{24{b[7]}}, b}, output_data);
            end
        end
    endtask

    task automatic test_uart_data();
        word_t d;
        int    tx_before;
        tests++;
        d         = next_random();
        tx_before = uart_dev.tx_count;
        access("uart_write", 1'b0, DEF_UART_DATA_ADDR, d, 1'b0);
        if (bus_snap[7:0] !== d[7:0]) begin
            report_mismatch("uart_write_bus", {24'h0, d[7:0]}, {24'h0, bus_snap[7:0]});
        end
        if (uart_dev.tx_count != tx_before + 1) begin
            report_mismatch("uart_write_count", tx_before + 1, uart_dev.tx_count);
        end
        if (uart_dev.tx_byte !== d[7:0]) begin
            report_mismatch("uart_write_byte", {24'h0, d[7:0]}, {24'h0, uart_dev.tx_byte});
        end
        d       = next_random();
        uart_rx = d[7:0] | 8'h80;   // high bit set, result must still be zero extended
        access("uart_read", 1'b1, DEF_UART_DATA_ADDR, '0, 1'b0);
        if (output_data !== {24'h0, uart_rx}) begin
            report_mismatch("uart_read", {24'h0, uart_rx}, output_data);
        end
    endtask

    task automatic test_uart_status();
        logic [1:0] combo;
        tests++;
        for (int i = 0; i < 4; i++) begin
            combo          = i[1:0];
            uart_dataready = combo[1];
            uart_tsre      = combo[0];
            access("uart_status", 1'b1, DEF_UART_STAT_ADDR, '0, 1'b0);
            if (output_data !== {30'h0, combo}) begin
                report_mismatch("uart_status", {30'h0, combo}, output_data);
            end
        end
    endtask

    task automatic test_back_to_back();
        word_t a1;
        word_t a2;
        word_t d1;
        word_t keep;
        tests++;
        a1   = next_random() & SRAM_MASK;
        a2   = a1 | EXT_BIT;
        d1   = next_random();
        keep = bank_word(a2);
        back_to_back("b2b_write", 1'b0, a1, d1, a2, next_random());
        if (bank_word(a1) !== d1) begin
            report_mismatch("b2b_write_first", d1, bank_word(a1));
        end
        if (bank_word(a2) !== keep) begin
            report_mismatch("b2b_write_second", keep, bank_word(a2));
        end
        back_to_back("b2b_read", 1'b1, a1, '0, a2, '0);
        if (output_data !== d1) begin
            report_mismatch("b2b_read", d1, output_data);
        end
    endtask

    initial begin
        rng            = 32'h1175_e097;
        reset          = 1'b1;
        if_read        = 1'b0;
        if_write       = 1'b0;
        bytemode       = 1'b0;
        addr           = '0;
        input_data     = '0;
        uart_dataready = 1'b0;
        uart_tsre      = 1'b0;
        uart_rx        = '0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        test_reset();
        test_word_rw();
        test_bytes();
        test_uart_data();
        test_uart_status();
        test_back_to_back();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
logic/mmu_pkg.sv
logic/addr_decode.sv
logic/mmu_ctrl.sv
logic/byte_lane.sv
logic/sram_port.sv
logic/mmu.sv
dv/board_model.sv
dv/mmu_assert.sv
dv/mmu_tb.sv

/* Makefile */
TOP = mmu_tb

all: run

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "all tests passed"

obj_dir/V$(TOP): vlog.f logic/*.sv dv/*.sv
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
